// File: src/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // Datapath and data RAM sizes
  localparam int xlen = 32;
  localparam int dmem_words = 256;
  localparam int dmem_addr_bits = 8;

  // ADDI x0,x0,0
  localparam logic [31:0] i_nop = 32'h0000_0013;
  localparam logic [31:0] i_ebreak = 32'h0010_0073;

  // Write-back source, order matches the WB result mux
  typedef enum logic [2:0] {
    res_alu  = 3'd0,
    res_load = 3'd1,
    res_pc4  = 3'd2,
    res_jb   = 3'd3,
    res_csr  = 3'd4,
    res_mext = 3'd5
  } res_src_e;

  // Load funct3 codes
  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_op_e;

  // Store funct3 codes
  typedef enum logic [2:0] {
    sb = 3'b000,
    sh = 3'b001,
    sw = 3'b010
  } store_op_e;

  // M-extension multiply funct3 codes
  typedef enum logic [2:0] {
    op_mul    = 3'b000,
    op_mulh   = 3'b001,
    op_mulhsu = 3'b010,
    op_mulhu  = 3'b011
  } mul_op_e;

  // Execute to MEM; alu_result doubles as the memory address
  typedef struct packed {
    logic valid;
    logic [31:0] instr;
    res_src_e res_src;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] jb_target;
    logic [xlen-1:0] csr_rdata;
    logic mem_read;
    logic mem_write;
    logic trap;
  } ex_mem_t;

  // MEM to WB, load data already extended, product still unsigned
  typedef struct packed {
    logic valid;
    logic [31:0] instr;
    res_src_e res_src;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] jb_target;
    logic [xlen-1:0] csr_rdata;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [63:0] product;
    logic trap;
  } mem_wb_t;

  // Register file write port
  typedef struct packed {
    logic we;
    logic [4:0] rd;
    logic [xlen-1:0] data;
  } wb_write_t;

  typedef struct packed {
    logic ebreak;
    logic trap;
    logic retired;
  } halt_t;

endpackage

`default_nettype wire

// File: src/rv_dmem.sv
`default_nettype none

module rv_dmem (
  input  logic                              clk,
  input  logic                              we,
  input  logic [3:0]                        strb,
  input  logic [rv_pkg::dmem_addr_bits-1:0] addr,
  input  logic [rv_pkg::xlen-1:0]           wdata,
  output logic [rv_pkg::xlen-1:0]           rdata
);

  // Word-wide storage, no reset on contents
  logic [rv_pkg::xlen-1:0] mem [rv_pkg::dmem_words];

  // Registered read, old contents seen on a same-edge write
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

  // One write enable per byte lane
  always_ff @(posedge clk) begin
    if (we && strb[0]) begin
      mem[addr][7:0] <= wdata[7:0];
    end
    if (we && strb[1]) begin
      mem[addr][15:8] <= wdata[15:8];
    end
    if (we && strb[2]) begin
      mem[addr][23:16] <= wdata[23:16];
    end
    if (we && strb[3]) begin
      mem[addr][31:24] <= wdata[31:24];
    end
  end

endmodule

`default_nettype wire

// File: src/rv_stage_mem.sv
`default_nettype none

module rv_stage_mem (
  input  logic                              clk,
  input  logic                              reset,
  input  rv_pkg::ex_mem_t                   ex_in,
  output logic                              dmem_we,
  output logic [3:0]                        dmem_strb,
  output logic [rv_pkg::dmem_addr_bits-1:0] dmem_addr,
  output logic [rv_pkg::xlen-1:0]           dmem_wdata,
  input  logic [rv_pkg::xlen-1:0]           dmem_rdata,
  output rv_pkg::mem_wb_t                   mem_wb
);

  rv_pkg::ex_mem_t ex_q;

  logic [1:0] st_off;
  logic [1:0] ld_off;
  logic [rv_pkg::xlen-1:0] ld_shift;
  logic [rv_pkg::xlen-1:0] ld_ext;

  logic rs1_signed;
  logic rs2_signed;
  logic [rv_pkg::xlen-1:0] mag1;
  logic [rv_pkg::xlen-1:0] mag2;
  logic [63:0] product;

  // Pipeline register, only valid is cleared
  always_ff @(posedge clk) begin
    ex_q <= ex_in;
    if (reset) begin
      ex_q.valid <= 1'b0;
    end
  end

  // RAM access issued straight from the incoming item
  assign st_off = ex_in.alu_result[1:0];
  assign dmem_addr = ex_in.alu_result[rv_pkg::dmem_addr_bits+1:2];
  // Hold RAM writes off during reset
  assign dmem_we = ex_in.valid && ex_in.mem_write && !reset;

  // Byte strobes and lane-replicated store data
  always_comb begin
    dmem_strb = 4'b0000;
    dmem_wdata = ex_in.rs2_data;
    case (rv_pkg::store_op_e'(ex_in.funct3))
      rv_pkg::sb: begin
        dmem_strb = 4'b0001 << st_off;
        dmem_wdata = {4{ex_in.rs2_data[7:0]}};
      end
      rv_pkg::sh: begin
        // Halfword lane picked by address bit 1
        dmem_strb = 4'b0011 << {st_off[1], 1'b0};
        dmem_wdata = {2{ex_in.rs2_data[15:0]}};
      end
      rv_pkg::sw: begin
        dmem_strb = 4'b1111;
      end
      default: begin
        dmem_strb = 4'b0000;
      end
    endcase
  end

  // Load lanes moved down to bit 0 first
  assign ld_off = ex_q.alu_result[1:0];
  assign ld_shift = dmem_rdata >> {ld_off, 3'b000};

  // Sign or zero extension by funct3
  always_comb begin
    case (rv_pkg::load_op_e'(ex_q.funct3))
      rv_pkg::lb:  ld_ext = {{24{ld_shift[7]}}, ld_shift[7:0]};
      rv_pkg::lh:  ld_ext = {{16{ld_shift[15]}}, ld_shift[15:0]};
      rv_pkg::lw:  ld_ext = ld_shift;
      rv_pkg::lbu: ld_ext = {24'b0, ld_shift[7:0]};
      rv_pkg::lhu: ld_ext = {16'b0, ld_shift[15:0]};
      default:     ld_ext = '0;
    endcase
  end

  // Which operands count as signed for this multiply
  always_comb begin
    case (rv_pkg::mul_op_e'(ex_q.funct3))
      rv_pkg::op_mul, rv_pkg::op_mulh: begin
        rs1_signed = 1'b1;
        rs2_signed = 1'b1;
      end
      rv_pkg::op_mulhsu: begin
        rs1_signed = 1'b1;
        rs2_signed = 1'b0;
      end
      default: begin
        // mulhu, also div codes
        rs1_signed = 1'b0;
        rs2_signed = 1'b0;
      end
    endcase
  end

  // Operand magnitudes; most negative maps to 2^31 as unsigned
  assign mag1 = (rs1_signed && ex_q.rs1_data[31]) ? (~ex_q.rs1_data + 32'd1) : ex_q.rs1_data;
  assign mag2 = (rs2_signed && ex_q.rs2_data[31]) ? (~ex_q.rs2_data + 32'd1) : ex_q.rs2_data;
  // Unsigned product only, sign fixed up in WB
  assign product = {32'b0, mag1} * {32'b0, mag2};

  // Assemble the WB bundle
  always_comb begin
    mem_wb.valid = ex_q.valid;
    mem_wb.instr = ex_q.instr;
    mem_wb.res_src = ex_q.res_src;
    mem_wb.funct3 = ex_q.funct3;
    mem_wb.rd = ex_q.rd;
    mem_wb.alu_result = ex_q.alu_result;
    mem_wb.load_data = ex_q.mem_read ? ld_ext : '0;
    mem_wb.pc_plus4 = ex_q.pc + 32'd4;
    mem_wb.jb_target = ex_q.jb_target;
    mem_wb.csr_rdata = ex_q.csr_rdata;
    mem_wb.rs1_data = ex_q.rs1_data;
    mem_wb.rs2_data = ex_q.rs2_data;
    mem_wb.product = product;
    mem_wb.trap = ex_q.trap;
  end

endmodule

`default_nettype wire

// File: src/rv_mul_fix.sv
`default_nettype none

module rv_mul_fix (
  input  logic [63:0]             product,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  input  rv_pkg::mul_op_e         op,
  output logic [rv_pkg::xlen-1:0] result
);

  logic negative;
  logic [63:0] fixed;

  // True result sign from op and operand signs
  always_comb begin
    case (op)
      rv_pkg::op_mul, rv_pkg::op_mulh: begin
        // Both signed
        negative = rs1_data[31] ^ rs2_data[31];
      end
      rv_pkg::op_mulhsu: begin
        // Only rs1 signed
        negative = rs1_data[31];
      end
      rv_pkg::op_mulhu: begin
        negative = 1'b0;
      end
      default: begin
        negative = 1'b0;
      end
    endcase
  end

  // Two's complement of the full 64-bit magnitude
  assign fixed = negative ? (~product + 64'd1) : product;

  // Low word for mul, high word for the rest
  assign result = (op == rv_pkg::op_mul) ? fixed[31:0] : fixed[63:32];

endmodule

`default_nettype wire

// File: src/rv_stage_wb.sv
`default_nettype none

module rv_stage_wb (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::mem_wb_t   mem_wb,
  output rv_pkg::wb_write_t wb,
  output rv_pkg::halt_t     halt
);

  rv_pkg::mem_wb_t mem_wb_q;

  logic [rv_pkg::xlen-1:0] mul_result;
  logic [rv_pkg::xlen-1:0] rd_data;

  // Pipeline register, payload left without reset
  always_ff @(posedge clk) begin
    mem_wb_q <= mem_wb;
    if (reset) begin
      mem_wb_q.valid <= 1'b0;
    end
  end

  // Sign correction of the MEM product
  // Div funct3 codes fall through the multiply path
  rv_mul_fix mul_fix_inst (
    .product  (mem_wb_q.product),
    .rs1_data (mem_wb_q.rs1_data),
    .rs2_data (mem_wb_q.rs2_data),
    .op       (rv_pkg::mul_op_e'(mem_wb_q.funct3)),
    .result   (mul_result)
  );

  // Result select
  always_comb begin
    case (mem_wb_q.res_src)
      rv_pkg::res_alu:  rd_data = mem_wb_q.alu_result;
      rv_pkg::res_load: rd_data = mem_wb_q.load_data;
      rv_pkg::res_pc4:  rd_data = mem_wb_q.pc_plus4;
      rv_pkg::res_jb:   rd_data = mem_wb_q.jb_target;
      rv_pkg::res_csr:  rd_data = mem_wb_q.csr_rdata;
      rv_pkg::res_mext: rd_data = mul_result;
      default:          rd_data = mem_wb_q.alu_result;
    endcase
  end

  // Register file write, x0 never written
  // Trapped items write nothing
  always_comb begin
    wb.we = mem_wb_q.valid && (mem_wb_q.rd != 5'd0) && !mem_wb_q.trap;
    wb.rd = mem_wb_q.rd;
    wb.data = rd_data;
  end

  // Halt and retire flags, all qualified by valid
  always_comb begin
    halt.ebreak = mem_wb_q.valid && (mem_wb_q.instr == rv_pkg::i_ebreak);
    halt.trap = mem_wb_q.valid && mem_wb_q.trap;
    // Bubbles and zero words don't count as retired
    halt.retired = mem_wb_q.valid
                   && (mem_wb_q.instr != 32'h0)
                   && (mem_wb_q.instr != rv_pkg::i_nop)
                   && !mem_wb_q.trap;
  end

endmodule

`default_nettype wire

// File: src/rv_backend.sv
`default_nettype none

module rv_backend (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::ex_mem_t   ex_in,
  output rv_pkg::wb_write_t wb,
  output rv_pkg::halt_t     halt
);

  // RAM port from MEM stage
  logic dmem_we;
  logic [3:0] dmem_strb;
  logic [rv_pkg::dmem_addr_bits-1:0] dmem_addr;
  logic [rv_pkg::xlen-1:0] dmem_wdata;
  logic [rv_pkg::xlen-1:0] dmem_rdata;

  // MEM to WB bundle
  rv_pkg::mem_wb_t mem_wb;

  // MEM stage, drives RAM at the input edge
  rv_stage_mem stage_mem_inst (
    .clk        (clk),
    .reset      (reset),
    .ex_in      (ex_in),
    .dmem_we    (dmem_we),
    .dmem_strb  (dmem_strb),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_rdata (dmem_rdata),
    .mem_wb     (mem_wb)
  );

  // Data RAM, one cycle read latency
  rv_dmem dmem_inst (
    .clk   (clk),
    .we    (dmem_we),
    .strb  (dmem_strb),
    .addr  (dmem_addr),
    .wdata (dmem_wdata),
    .rdata (dmem_rdata)
  );

  // WB stage, outputs two edges after input
  rv_stage_wb stage_wb_inst (
    .clk    (clk),
    .reset  (reset),
    .mem_wb (mem_wb),
    .wb     (wb),
    .halt   (halt)
  );

endmodule

`default_nettype wire

// File: bench/rv_backend_tb.sv
`default_nettype none

module rv_backend_tb;

  // Ten 32-bit words per pattern line
  localparam int num_patterns = 48;
  localparam int words_per_pattern = 10;
  // Reset, one back-to-back pass, one pass with up to three idle cycles per item
  localparam int watchdog_time = (num_patterns * 5 + 40) * 20;

  logic clk;
  logic reset;
  rv_pkg::ex_mem_t ex_in;
  rv_pkg::wb_write_t wb;
  rv_pkg::halt_t halt;

  logic [31:0] pat_mem [num_patterns * words_per_pattern];

  // Expected outputs for the items one and two cycles back
  rv_pkg::wb_write_t wb_pipe [2];
  rv_pkg::halt_t halt_pipe [2];

  logic [15:0] lfsr;
  int checks;
  int wb_errors;
  int halt_errors;

  rv_backend rv_backend_inst (
    .clk   (clk),
    .reset (reset),
    .ex_in (ex_in),
    .wb    (wb),
    .halt  (halt)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Control nibbles: valid, res_src, funct3, rd byte, mem_read, mem_write, trap
  function automatic rv_pkg::ex_mem_t item_from_file(input int idx);
    rv_pkg::ex_mem_t item;
    logic [31:0] ctl;
    int base;
    base = idx * words_per_pattern;
    ctl = pat_mem[base];
    item = '0;
    item.valid = ctl[28];
    item.res_src = rv_pkg::res_src_e'(ctl[26:24]);
    item.funct3 = ctl[22:20];
    item.rd = ctl[16:12];
    item.mem_read = ctl[8];
    item.mem_write = ctl[4];
    item.trap = ctl[0];
    item.instr = pat_mem[base + 1];
    item.alu_result = pat_mem[base + 2];
    item.rs1_data = pat_mem[base + 3];
    item.rs2_data = pat_mem[base + 4];
    item.pc = pat_mem[base + 5];
    item.jb_target = pat_mem[base + 6];
    item.csr_rdata = pat_mem[base + 7];
    return item;
  endfunction

  // Expected nibbles: we, 0, 0, rd byte, ebreak, trap, retired
  function automatic rv_pkg::wb_write_t expected_wb(input int idx);
    rv_pkg::wb_write_t exp_wb;
    logic [31:0] ctl;
    ctl = pat_mem[idx * words_per_pattern + 8];
    exp_wb.we = ctl[28];
    exp_wb.rd = ctl[16:12];
    exp_wb.data = pat_mem[idx * words_per_pattern + 9];
    return exp_wb;
  endfunction

  function automatic rv_pkg::halt_t expected_halt(input int idx);
    rv_pkg::halt_t exp_halt;
    logic [31:0] ctl;
    ctl = pat_mem[idx * words_per_pattern + 8];
    exp_halt.ebreak = ctl[8];
    exp_halt.trap = ctl[4];
    exp_halt.retired = ctl[0];
    return exp_halt;
  endfunction

  // Destination and data only matter when a write is expected
  task automatic check_wb(input rv_pkg::wb_write_t got, input rv_pkg::wb_write_t exp_wb);
    checks++;
    if (got.we !== exp_wb.we) begin
      $display("error: wb.we got %h expected %h at %0t", got.we, exp_wb.we, $time);
      wb_errors++;
    end else if (exp_wb.we && (got.rd !== exp_wb.rd)) begin
      $display("error: wb.rd got %h expected %h at %0t", got.rd, exp_wb.rd, $time);
      wb_errors++;
    end else if (exp_wb.we && (got.data !== exp_wb.data)) begin
      $display("error: wb.data got %h expected %h at %0t", got.data, exp_wb.data, $time);
      wb_errors++;
    end
  endtask

  task automatic check_halt(input rv_pkg::halt_t got, input rv_pkg::halt_t exp_halt);
    checks++;
    if (got !== exp_halt) begin
      $display("error: halt got %h expected %h at %0t", got, exp_halt, $time);
      halt_errors++;
    end
  endtask

  // Check the item from two cycles back, then drive the next one
  task automatic apply_cycle(input rv_pkg::ex_mem_t item, input rv_pkg::wb_write_t exp_wb,
                             input rv_pkg::halt_t exp_halt);
    check_wb(wb, wb_pipe[1]);
    check_halt(halt, halt_pipe[1]);
    wb_pipe[1] = wb_pipe[0];
    halt_pipe[1] = halt_pipe[0];
    wb_pipe[0] = exp_wb;
    halt_pipe[0] = exp_halt;
    ex_in = item;
    @(posedge clk);
    #2;
  endtask

  // Two LFSR bits give 0 to 3 idle cycles
  task automatic draw_gap(output int gap);
    gap = 0;
    repeat (2) begin
      lfsr = lfsr_step(lfsr);
      gap = (gap << 1) | lfsr[0];
    end
  endtask

  initial begin
    rv_pkg::ex_mem_t item;
    rv_pkg::ex_mem_t idle;
    int gap;
    reset = 1'b1;
    ex_in = '0;
    lfsr = 16'd13518;
    checks = 0;
    wb_errors = 0;
    halt_errors = 0;
    wb_pipe[0] = '0;
    wb_pipe[1] = '0;
    halt_pipe[0] = '0;
    halt_pipe[1] = '0;
    $readmemh("bench/rv_backend_patterns.hex", pat_mem);
    // A valid writing item held on the input while reset is high
    ex_in = item_from_file(0);
    repeat (10) begin
      @(posedge clk);
      #2;
      check_wb(wb, '0);
      check_halt(halt, '0);
    end
    reset = 1'b0;
    // Pass 0 back to back, pass 1 with idle gaps
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < num_patterns; i++) begin
        item = item_from_file(i);
        apply_cycle(item, expected_wb(i), expected_halt(i));
        if (pass == 1) begin
          draw_gap(gap);
          // Idle keeps the payload with valid low
          idle = item;
          idle.valid = 1'b0;
          repeat (gap) begin
            apply_cycle(idle, '0, '0);
          end
        end
      end
    end
    idle = item;
    idle.valid = 1'b0;
    // Drain the two items still in flight
    repeat (2) begin
      apply_cycle(idle, '0, '0);
    end
    $display("checks %0d, wb errors %0d, halt errors %0d", checks, wb_errors, halt_errors);
    if ((wb_errors + halt_errors) == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_time);
    $display("Timeout: the pattern replay did not finish in the expected time");
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/rv_backend_patterns.hex
// ctl(valid res_src funct3 rd rd mem_read mem_write trap) instr alu_result rs1 rs2 pc
// jb_target csr_rdata exp(we 0 0 rd rd ebreak trap retired) exp_data
10005000 002082B3 12345678 00000011 00000022 00000400 00000500 00000600 10005001 12345678
10000000 00208033 DEADBEEF 00000011 00000022 00000404 00000504 00000604 00000001 00000000
12001000 008000EF 00000000 00000000 00000000 00000200 00000208 00000000 10001001 00000204
12001000 000080E7 00000300 00000300 00000000 FFFFFFFC 00000300 00000000 10001001 00000000
13007000 00001397 00000000 00000000 00000000 00000200 00001200 00000000 10007001 00001200
1400A000 30002573 00000000 00000000 00000000 00000208 00000000 00001800 1000A001 00001800
10000000 00000013 00000000 00000000 00000000 0000020C 00000000 00000000 00000000 00000000
10000000 00000000 00000000 00000000 00000000 00000210 00000000 00000000 00000000 00000000
10000000 00100073 00000000 00000000 00000000 00000214 00000000 00000000 00000101 00000000
10006001 0020A303 00000103 00000101 00000000 00000218 00000000 00000000 00000010 00000000
10200010 10202023 00000100 00000000 11223344 00000300 00000000 00000000 00000001 00000000
10200010 10202223 00000104 00000000 8899AABB 00000304 00000000 00000000 00000001 00000000
11206100 10002303 00000100 00000000 00000000 00000308 00000000 00000000 10006001 11223344
11007100 10400383 00000104 00000000 00000000 0000030C 00000000 00000000 10007001 FFFFFFBB
11407100 10504383 00000105 00000000 00000000 00000310 00000000 00000000 10007001 000000AA
11008100 10600403 00000106 00000000 00000000 00000314 00000000 00000000 10008001 FFFFFF99
11408100 10704403 00000107 00000000 00000000 00000318 00000000 00000000 10008001 00000088
11009100 10100483 00000101 00000000 00000000 0000031C 00000000 00000000 10009001 00000033
11109100 10401483 00000104 00000000 00000000 00000320 00000000 00000000 10009001 FFFFAABB
11509100 10605483 00000106 00000000 00000000 00000324 00000000 00000000 10009001 00008899
1110A100 10201503 00000102 00000000 00000000 00000328 00000000 00000000 1000A001 00001122
10200010 10202423 00000108 00000000 A5A5A5A5 0000032C 00000000 00000000 00000001 00000000
10000010 10200423 00000108 00000000 123456C1 00000330 00000000 00000000 00000001 00000000
10000010 102004A3 00000109 00000000 FFFFFFD2 00000334 00000000 00000000 00000001 00000000
10000010 10200523 0000010A 00000000 000000E3 00000338 00000000 00000000 00000001 00000000
10000010 102005A3 0000010B 00000000 777777F4 0000033C 00000000 00000000 00000001 00000000
1120B100 10802583 00000108 00000000 00000000 00000340 00000000 00000000 1000B001 F4E3D2C1
10100010 10201423 00000108 00000000 ABCD1357 00000344 00000000 00000000 00000001 00000000
10100010 10201523 0000010A 00000000 0000BEEF 00000348 00000000 00000000 00000001 00000000
1120C100 10802603 00000108 00000000 00000000 0000034C 00000000 00000000 1000C001 BEEF1357
1110C100 10A01603 0000010A 00000000 00000000 00000350 00000000 00000000 1000C001 FFFFBEEF
1150D100 10805683 00000108 00000000 00000000 00000354 00000000 00000000 1000D001 00001357
1120E110 0C20272F 00000100 00000100 CAFEF00D 00000358 00000000 00000000 1000E001 11223344
1120F100 10002783 00000100 00000000 00000000 0000035C 00000000 00000000 1000F001 CAFEF00D
15005000 022082B3 00000000 00000007 00000006 00000400 00000000 00000000 10005001 0000002A
15006000 022082B3 00000000 FFFFFFFD 00000005 00000404 00000000 00000000 10006001 FFFFFFF1
15107000 022092B3 00000000 FFFFFFFD 00000005 00000408 00000000 00000000 10007001 FFFFFFFF
15108000 022092B3 00000000 80000000 80000000 0000040C 00000000 00000000 10008001 40000000
15109000 022092B3 00000000 80000000 7FFFFFFF 00000410 00000000 00000000 10009001 C0000000
1500A000 022082B3 00000000 80000000 7FFFFFFF 00000414 00000000 00000000 1000A001 80000000
1520B000 0220A2B3 00000000 FFFFFFFF FFFFFFFF 00000418 00000000 00000000 1000B001 FFFFFFFF
1520C000 0220A2B3 00000000 00000002 80000000 0000041C 00000000 00000000 1000C001 00000001
1520D000 0220A2B3 00000000 80000000 00000003 00000420 00000000 00000000 1000D001 FFFFFFFE
1530E000 0220B2B3 00000000 FFFFFFFF FFFFFFFF 00000424 00000000 00000000 1000E001 FFFFFFFE
1530F000 0220B2B3 00000000 80000000 00000004 00000428 00000000 00000000 1000F001 00000002
15110000 022092B3 00000000 00000000 FFFFFFFB 0000042C 00000000 00000000 10010001 00000000
15211000 0220A2B3 00000000 FFFFFFFF 00000000 00000430 00000000 00000000 10011001 00000000
15112000 022092B3 00000000 00012345 00100000 00000434 00000000 00000000 10012001 00000012

// File: sim.f
src/rv_pkg.sv
src/rv_dmem.sv
src/rv_stage_mem.sv
src/rv_mul_fix.sv
src/rv_stage_wb.sv
src/rv_backend.sv
bench/rv_backend_tb.sv
